// File: build.f
+incdir+include
src/ddrmux_pkg.sv
src/ddr_owner_fsm.sv
src/credit_counter.sv
src/ddr_port_mux.sv
src/ddr_arb_top.sv
dv/ddr_arb_props.sv
dv/ddr_arb_tb.sv

// File: run.sh
#!/bin/sh
# Builds the DDR arbiter testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module ddr_arb_tb -o ddr_arb_sim

out=$(./obj_dir/ddr_arb_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// File: dv/ddr_arb_tb.sv
// Testbench for the DDR command arbiter. Ownership checks assume both requesters are enabled.
// The memory side lives here and returns one credit per command after 1 to 6 cycles.
`timescale 1ns/10ps
`include "ddrmux_consts.svh"

module ddr_arb_tb import ddrmux_pkg::*; ();

    localparam int     CLK_PERIOD   = 100;
    localparam int     CREDITS      = `DDRMUX_CREDITS;
    localparam int     DELAY_MAX    = 6;   // worst credit return delay in cycles.
    localparam int     DRAIN_MARGIN = 4;
    localparam int     PHASE_CMDS   = 16;  // commands per directed phase.
    localparam int     MIX_CYCLES   = 400;
    localparam int     MAX_CMDS     = 4 * PHASE_CMDS + MIX_CYCLES;
    localparam longint WATCHDOG_NS  =
        longint'(MAX_CMDS) * (DELAY_MAX + DRAIN_MARGIN) * CLK_PERIOD;

    // dut ports.
    logic     clk            = 1'b0;
    logic     rst            = 1'b0;
    logic     downloading    = 1'b0;
    ddr_cmd_t load_cmd       = '0;
    logic     load_valid     = 1'b0;
    logic     load_ready;
    ddr_cmd_t rot_cmd        = '0;
    logic     rot_valid      = 1'b0;
    logic     rot_ready;
    ddr_cmd_t ddr_cmd;
    logic     ddr_cmd_valid;
    logic     ddr_credit_ret = 1'b0;

    // stimulus knobs, set by the sequence.
    int   load_rate    = 0;     // percent chance of a new loader request per cycle.
    int   rot_rate     = 0;
    int   toggle_rate  = 0;     // percent chance of flipping downloading.
    logic dl_want      = 1'b0;  // downloading level when not toggling.
    logic hold_credits = 1'b0;  // memory side withholds all returns.

    // scoreboard state.
    integer   seed;
    int       cycle       = 0;
    int       outstanding = 0;  // accepted minus returned.
    int       load_count  = 0;
    int       rot_count   = 0;
    owner_t   last_src    = OWN_ROT;
    logic     load_acc    = 1'b0;
    logic     rot_acc     = 1'b0;
    logic     dl_prev     = 1'b0;
    ddr_cmd_t exp_q[$];
    int       due_q[$];         // cycle at which each credit may go back.

    ddr_arb_top dut (
        .clk            (clk),
        .rst            (rst),
        .downloading    (downloading),
        .load_cmd       (load_cmd),
        .load_valid     (load_valid),
        .load_ready     (load_ready),
        .rot_cmd        (rot_cmd),
        .rot_valid      (rot_valid),
        .rot_ready      (rot_ready),
        .ddr_cmd        (ddr_cmd),
        .ddr_cmd_valid  (ddr_cmd_valid),
        .ddr_credit_ret (ddr_credit_ret)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % 32'(hi - lo + 1));
    endfunction

    function automatic ddr_cmd_t random_cmd();
        ddr_cmd_t    c;
        logic [31:0] r;
        r          = $random(seed);
        c.op       = r[31] ? OP_WRITE : OP_READ;
        c.addr     = r[`DDRMUX_ADDR_W-1:0];
        r          = $random(seed);
        c.burstcnt = r[`DDRMUX_BURST_W-1:0];
        c.be       = r[`DDRMUX_BURST_W +: `DDRMUX_BE_W];
        return c;
    endfunction

    // reference: loader leaves as a full-width read, rotation untouched.
    function automatic ddr_cmd_t expected_cmd(input owner_t src, input ddr_cmd_t c);
        ddr_cmd_t e;
        e = c;
        if (src == OWN_LOAD) begin
            e.op = OP_READ;
            e.be = '1;
        end
        return e;
    endfunction

    // requesters and memory side, driven 1 ns after each rising edge.
    always @(posedge clk) begin
        #1;
        cycle = cycle + 1;
        ddr_credit_ret = 1'b0;
        if (ddr_cmd_valid) due_q.push_back(cycle + rand_range(1, DELAY_MAX));
        if (!hold_credits && due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            ddr_credit_ret = 1'b1;  // one return per cycle at most.
        end
        if (toggle_rate > 0) begin
            if (rand_range(0, 99) < toggle_rate) downloading = ~downloading;
        end else begin
            downloading = dl_want;
        end
        if (load_acc) load_valid = 1'b0;  // taken at this edge.
        if (!load_valid && rand_range(0, 99) < load_rate) begin
            load_cmd   = random_cmd();
            load_valid = 1'b1;
        end
        if (rot_acc) rot_valid = 1'b0;
        if (!rot_valid && rand_range(0, 99) < rot_rate) begin
            rot_cmd   = random_cmd();
            rot_valid = 1'b1;
        end
    end

    // pops one expected command per port pulse.
    // An accept must show up on the very next cycle.
    task automatic check_port();
        ddr_cmd_t exp;
        if (ddr_cmd_valid) begin
            assert (exp_q.size() > 0)
                else report_failure("command on the DDR port with none expected");
            exp = exp_q.pop_front();
            assert (ddr_cmd == exp)
                else report_failure($sformatf("FAIL ddr_cmd expected %h got %h", exp, ddr_cmd));
        end else begin
            assert (exp_q.size() == 0)
                else report_failure("accepted command did not appear on the DDR port");
        end
    endtask

    // ownership and credit rules seen from the requester side.
    task automatic check_ready();
        assert (!(load_ready && rot_ready))
            else report_failure("load_ready and rot_ready high in the same cycle");
        assert (!load_ready || dl_prev)
            else report_failure("load_ready high while downloading was low");
        assert (!rot_ready || !dl_prev)
            else report_failure("rot_ready high while downloading was high");
        if (load_ready || rot_ready) begin
            assert (outstanding < CREDITS)
                else report_failure("ready high with every credit in flight");
        end
        // a new owner only once the old one's commands are all back.
        if ((load_ready && last_src != OWN_LOAD) || (rot_ready && last_src != OWN_ROT)) begin
            assert (outstanding == 0)
                else report_failure("new owner granted before old commands completed");
        end
    endtask

    task automatic accept(input owner_t src, input ddr_cmd_t c);
        exp_q.push_back(expected_cmd(src, c));
        outstanding = outstanding + 1;
        last_src    = src;
        if (src == OWN_LOAD) begin
            load_count = load_count + 1;
        end else begin
            rot_count = rot_count + 1;
        end
    endtask

    // comparator, samples at the falling edge where everything is settled.
    always @(negedge clk) begin
        if (!rst) begin
            check_port();
            check_ready();
            if (load_valid && load_ready) accept(OWN_LOAD, load_cmd);
            if (rot_valid && rot_ready) accept(OWN_ROT, rot_cmd);
            if (ddr_credit_ret) outstanding = outstanding - 1;  // counted at next edge.
            assert (outstanding >= 0 && outstanding <= CREDITS)
                else report_failure($sformatf("%0d commands outstanding", outstanding));
        end
        load_acc = load_valid && load_ready && !rst;
        rot_acc  = rot_valid && rot_ready && !rst;
        dl_prev  = downloading;
    end

    task automatic wait_accepts(input owner_t src, input int n);
        int target;
        target = ((src == OWN_LOAD) ? load_count : rot_count) + n;
        while (((src == OWN_LOAD) ? load_count : rot_count) < target) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_outstanding(input int n);
        while (outstanding < n) begin
            @(posedge clk);
        end
    endtask

    initial begin
        int waited;
        seed = 32'h9168_116a;
        rst  = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        // idle port after reset, then plain rotation traffic.
        repeat (4) @(posedge clk);
        rot_rate = 100;
        wait_accepts(OWN_ROT, PHASE_CMDS);

        // switch to the loader under rotation load and back.
        rot_rate  = 60;
        load_rate = 100;
        dl_want   = 1'b1;
        wait_accepts(OWN_LOAD, PHASE_CMDS);
        dl_want = 1'b0;
        wait_accepts(OWN_ROT, PHASE_CMDS);

        // download drops again mid drain.
        hold_credits = 1'b1;  // keeps the drain open.
        wait_outstanding(1);
        dl_want = 1'b1;
        repeat (3) @(posedge clk);
        dl_want = 1'b0;
        repeat (2) @(posedge clk);
        hold_credits = 1'b0;
        wait_accepts(OWN_ROT, 4);

        // credit limit, all returns withheld.
        load_rate    = 0;
        rot_rate     = 100;
        hold_credits = 1'b1;
        wait_outstanding(CREDITS);
        repeat (5) begin
            @(negedge clk);
            assert (rot_valid && !rot_ready)
                else report_failure("rotation request not held back with no credits left");
        end
        hold_credits = 1'b0;
        wait_accepts(OWN_ROT, PHASE_CMDS);

        // long random mix.
        load_rate   = 70;
        rot_rate    = 70;
        toggle_rate = 5;
        repeat (MIX_CYCLES) @(posedge clk);

        // flush the held requests of both sides.
        load_rate   = 0;
        rot_rate    = 0;
        toggle_rate = 0;
        dl_want     = 1'b1;
        while (load_valid) begin
            @(posedge clk);
        end
        dl_want = 1'b0;
        while (rot_valid) begin
            @(posedge clk);
        end
        waited = 0;
        while ((exp_q.size() > 0 || outstanding > 0) &&
               waited < CREDITS * DELAY_MAX + DRAIN_MARGIN) begin
            @(posedge clk);
            waited = waited + 1;
        end

        if (exp_q.size() == 0 && outstanding == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            report_failure($sformatf("%0d commands still expected, %0d outstanding at end",
                                     exp_q.size(), outstanding));
        end
    end

    // watchdog, sized from the command count and worst credit delay.
    initial begin
        #(WATCHDOG_NS);
        report_failure("timeout: the test did not complete in time");
    end

endmodule

// File: dv/ddr_arb_props.sv
// Concurrent checks bound into ddr_arb_top. They look at the owner FSM state and credit count.
// The count width follows the credit depth in the consts header.
`timescale 1ns/10ps
`include "ddrmux_consts.svh"

module ddr_arb_props import ddrmux_pkg::*; #(
    parameter int CNT_W = $clog2(`DDRMUX_CREDITS + 1)
) (
    input logic             clk,
    input logic             rst,
    input logic             ddr_cmd_valid,  // registered issue pulse.
    input logic             credit_avail,
    input logic             load_ready,
    input logic             rot_ready,
    input owner_state_t     state,          // owner fsm state.
    input logic [CNT_W-1:0] count           // free credits.
);

    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`DDRMUX_CREDITS);

    // a pulse on the port traces back to an issue with a free slot.
    valid_needs_credit: assert property (
        @(posedge clk) disable iff (rst)
        ddr_cmd_valid |-> $past(credit_avail)
    ) else $error("ddr_cmd_valid pulsed for an issue made with no free credit");

    // drain states grant nobody.
    no_ready_in_drain: assert property (
        @(posedge clk) disable iff (rst)
        (state == ST_DRAIN_TO_LOAD || state == ST_DRAIN_TO_ROT) |-> !(load_ready || rot_ready)
    ) else $error("a ready was high while the owner FSM was draining");

    // never more free credits than the memory side holds.
    count_in_bound: assert property (
        @(posedge clk) disable iff (rst)
        count <= CNT_MAX
    ) else $error("credit count above its limit");

endmodule

bind ddr_arb_top ddr_arb_props u_props (
    .clk           (clk),
    .rst           (rst),
    .ddr_cmd_valid (ddr_cmd_valid),
    .credit_avail  (credit_avail),
    .load_ready    (load_ready),
    .rot_ready     (rot_ready),
    .state         (u_owner_fsm.state),
    .count         (u_credit.count)
);

// File: src/ddr_arb_top.sv
// Arbitrates the rom loader and the rotation engine onto one DDR command port.
// The memory side applies no back-pressure. One credit must return per issued command.
`timescale 1ns/10ps

module ddr_arb_top import ddrmux_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     downloading,     // rom download active.
    // rom loader
    input  ddr_cmd_t load_cmd,
    input  logic     load_valid,
    output logic     load_ready,
    // frame-buffer rotation
    input  ddr_cmd_t rot_cmd,
    input  logic     rot_valid,
    output logic     rot_ready,
    // ddr command port
    output ddr_cmd_t ddr_cmd,
    output logic     ddr_cmd_valid,
    input  logic     ddr_credit_ret  // one pulse per completed command.
);

    owner_t owner;
    logic   grant_en;
    logic   drained;
    logic   credit_avail;
    logic   issue;

    // ready uses registered state only. It never looks at valid.
    assign load_ready = grant_en & credit_avail & (owner == OWN_LOAD);
    assign rot_ready  = grant_en & credit_avail & (owner == OWN_ROT);

    // at most one ready is high, so at most one accept per cycle.
    assign issue = (load_valid & load_ready) | (rot_valid & rot_ready);

    ddr_owner_fsm u_owner_fsm (
        .clk         (clk),
        .rst         (rst),
        .downloading (downloading),
        .drained     (drained),
        .owner       (owner),
        .grant_en    (grant_en)
    );

    credit_counter u_credit (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .credit_ret   (ddr_credit_ret),
        .credit_avail (credit_avail),
        .drained      (drained)
    );

    ddr_port_mux u_port_mux (
        .clk           (clk),
        .rst           (rst),
        .owner         (owner),
        .load_cmd      (load_cmd),
        .rot_cmd       (rot_cmd),
        .issue         (issue),
        .ddr_cmd       (ddr_cmd),
        .ddr_cmd_valid (ddr_cmd_valid)
    );

endmodule

// File: src/ddr_port_mux.sv
// Selects the owner's command and drives it onto the DDR port one cycle after acceptance.
// Loader commands always leave as full-width reads. Their op and be fields are ignored.
`timescale 1ns/10ps
`include "ddrmux_consts.svh"

module ddr_port_mux import ddrmux_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  owner_t   owner,          // current port owner.
    input  ddr_cmd_t load_cmd,       // loader request.
    input  ddr_cmd_t rot_cmd,        // rotation request.
    input  logic     issue,          // owner's command accepted.
    output ddr_cmd_t ddr_cmd,        // registered command to ddr.
    output logic     ddr_cmd_valid   // one pulse per command.
);

    ddr_cmd_t sel_cmd;

    // owner select with the loader rewrite.
    always_comb begin
        if (owner == OWN_LOAD) begin
            sel_cmd.op       = OP_READ;                 // loader only reads.
            sel_cmd.addr     = load_cmd.addr;
            sel_cmd.burstcnt = load_cmd.burstcnt;
            sel_cmd.be       = {`DDRMUX_BE_W{1'b1}};  // all lanes.
        end else begin
            sel_cmd = rot_cmd;  // rotation passes untouched.
        end
    end

    // valid pulse.
    // It lasts exactly one cycle per accepted request.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ddr_cmd_valid <= 1'b0;
        end else begin
            ddr_cmd_valid <= issue;
        end
    end

    // payload only loads on issue.
    // It is don't care while valid is low.
    always_ff @(posedge clk) begin
        if (issue) begin
            ddr_cmd <= sel_cmd;
        end
    end

endmodule

// File: src/credit_counter.sv
// Tracks free command slots on the DDR side. The count starts full after reset.
// issue must only be raised while credit_avail is high.
`timescale 1ns/10ps
`include "ddrmux_consts.svh"

module credit_counter (
    input  logic clk,
    input  logic rst,
    input  logic issue,         // command accepted this cycle.
    input  logic credit_ret,    // memory side finished one command.
    output logic credit_avail,  // at least one slot free.
    output logic drained        // nothing in flight.
);

    localparam int CREDITS = `DDRMUX_CREDITS;
    localparam int CNT_W   = $clog2(CREDITS + 1);

    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(CREDITS);

    // free credits.
    logic [CNT_W-1:0] count;

    // up/down counter.
    // issue and return in the same cycle cancel out.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= CNT_FULL;
        end else begin
            unique case ({issue, credit_ret})
                2'b10:   count <= count - 1'b1;  // one more in flight.
                2'b01:   count <= count + 1'b1;  // one came back.
                default: count <= count;         // idle or both.
            endcase
        end
    end

    // both flags come straight from the register.
    // A returned credit shows up next cycle.
    assign credit_avail = (count != '0);
    assign drained      = (count == CNT_FULL);

endmodule

// File: src/ddr_owner_fsm.sv
// Decides which requester owns the DDR port. A switch waits until all credits return.
// downloading is expected synchronous to clk. The enables are read from the consts header.
`timescale 1ns/10ps
`include "ddrmux_consts.svh"

module ddr_owner_fsm import ddrmux_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   downloading,  // rom download in progress.
    input  logic   drained,      // all credits back from ddr.
    output owner_t owner,        // current owner, held through the drain.
    output logic   grant_en      // low while draining.
);

    localparam bit LOAD_EN = (`DDRMUX_LOAD_EN != 0);
    localparam bit ROT_EN  = (`DDRMUX_ROT_EN != 0);

    // loader only config starts and stays on the loader.
    localparam owner_state_t RST_STATE = (LOAD_EN && !ROT_EN) ? ST_LOAD : ST_ROT;

    owner_state_t state;
    owner_state_t next_state;
    logic         want_load;

    // wanted owner.
    // With one requester present it is fixed.
    always_comb begin
        if (LOAD_EN && ROT_EN) begin
            want_load = downloading;
        end else begin
            want_load = LOAD_EN;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            ST_ROT: begin
                if (want_load) next_state = ST_DRAIN_TO_LOAD;  // start switchover.
            end
            ST_DRAIN_TO_LOAD: begin
                if (!want_load) begin
                    next_state = ST_ROT;      // download dropped, back to rot at once.
                end else if (drained) begin
                    next_state = ST_LOAD;     // nothing in flight, hand over.
                end
            end
            ST_LOAD: begin
                if (!want_load) next_state = ST_DRAIN_TO_ROT;
            end
            ST_DRAIN_TO_ROT: begin
                if (want_load) begin
                    next_state = ST_LOAD;     // download resumed, loader keeps port.
                end else if (drained) begin
                    next_state = ST_ROT;
                end
            end
            default: next_state = RST_STATE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= RST_STATE;
        end else begin
            state <= next_state;
        end
    end

    // owner decodes from state.
    // A drain still names the old owner.
    always_comb begin
        unique case (state)
            ST_LOAD, ST_DRAIN_TO_ROT: owner = OWN_LOAD;
            default:                  owner = OWN_ROT;
        endcase
    end

    // no grants in a drain state.
    assign grant_en = (state == ST_ROT) || (state == ST_LOAD);

endmodule

// File: src/ddrmux_pkg.sv
// Shared types for the DDR command arbiter.
// Field widths come from the consts header and must agree with the DDR controller.
`include "ddrmux_consts.svh"

package ddrmux_pkg;

    // command opcode on the ddr port.
    typedef enum logic [0:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cmd_op_t;

    // one ddr command, 46 bits with default widths.
    typedef struct packed {
        cmd_op_t                    op;        // read or write.
        logic [`DDRMUX_ADDR_W-1:0]  addr;      // word address.
        logic [`DDRMUX_BURST_W-1:0] burstcnt;  // beats in the burst.
        logic [`DDRMUX_BE_W-1:0]    be;        // byte enables.
    } ddr_cmd_t;

    // current owner of the ddr command port.
    typedef enum logic [0:0] {
        OWN_ROT  = 1'b0,
        OWN_LOAD = 1'b1
    } owner_t;

    // owner fsm states.
    // A switchover passes through a drain state first.
    typedef enum logic [1:0] {
        ST_ROT           = 2'd0,  // rotation owns port.
        ST_DRAIN_TO_LOAD = 2'd1,  // waiting for rot commands to finish.
        ST_LOAD          = 2'd2,  // loader owns port.
        ST_DRAIN_TO_ROT  = 2'd3   // waiting for loader commands to finish.
    } owner_state_t;

endpackage

// File: include/ddrmux_consts.svh
// Field widths, credit depth and requester enables for the DDR command arbiter.
// The enables take 0 or 1. If only one is set, that requester owns the port permanently.
`ifndef DDRMUX_CONSTS_SVH
`define DDRMUX_CONSTS_SVH

// command field widths, matching the DDR port.
`define DDRMUX_ADDR_W   29  // ddr word address.
`define DDRMUX_BURST_W  8   // burst count.
`define DDRMUX_BE_W     8   // byte enables, one per byte lane.

// commands the memory side can hold before it returns credits.
`define DDRMUX_CREDITS  4

// requester presence.
// loader stands in for the fast rom download path.
`define DDRMUX_LOAD_EN  1
// rot stands in for the frame-buffer rotation engine.
`define DDRMUX_ROT_EN   1

`endif
